//--- src.f
+incdir+hdl
+incdir+test
hdl/noc_flit_pkg.sv
hdl/noc_route_pkg.sv
hdl/route_guide.sv
hdl/sw_alloc.sv
hdl/vc_data_crossbar.sv
hdl/vc_router_sw.sv
test/tb_vc_router_sw.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f \
   --top-module tb_vc_router_sw \
   -o tb_vc_router_sw

./obj_dir/tb_vc_router_sw | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
   echo "simulation passed, see sim.log"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

//--- test/tb_router_model.svh
`ifndef TB_ROUTER_MODEL_SVH
`define TB_ROUTER_MODEL_SVH

// port numbers of this router
localparam int SOUTH = 0;
localparam int WEST  = 1;
localparam int NORTH = 2;
localparam int EAST  = 3;
localparam int LOCAL = 4;
localparam int NSRC  = 5 * `NOC_VCN;  // input vcs, port major

logic [31:0] lfsr_state = 32'hba45_2439;

// expected flits {type, data} per output port and source vc
logic [33:0] exp_q [5*NSRC][$];

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] take_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r          = {r[30:0], lfsr_state[0]};
   end
   return r;
endfunction

// y first, then x
function automatic int ref_route(input int dx, input int dy);
   if (dy > `NOC_ROUTER_Y) return NORTH;
   if (dy < `NOC_ROUTER_Y) return SOUTH;
   if (dx > `NOC_ROUTER_X) return EAST;
   if (dx < `NOC_ROUTER_X) return WEST;
   return LOCAL;
endfunction

function automatic logic turn_allowed(input int src, input int dst);
   case (src)
      SOUTH:   return dst != SOUTH;
      NORTH:   return dst != NORTH;
      WEST:    return (dst == EAST) || (dst == LOCAL);
      EAST:    return (dst == WEST) || (dst == LOCAL);
      default: return dst != LOCAL;
   endcase
endfunction

function automatic int queue_slot(input int port, input int p, input int v);
   return (port * 5 + p) * `NOC_VCN + v;
endfunction

function automatic logic scoreboard_empty();
   for (int i = 0; i < 5 * NSRC; i++)
      if (exp_q[i].size() != 0) return 1'b0;
   return 1'b1;
endfunction

`endif

//--- test/tb_vc_router_sw.sv
`timescale 1ns/1ps
`include "noc_defines.svh"

module tb_vc_router_sw;

   logic                                          clk;
   logic                                          rst_n;
   logic [4:0][`NOC_VCN-1:0]                      in_valid;
   logic [4:0][`NOC_VCN-1:0]                      in_ready;
   noc_flit_pkg::flit_type_t [4:0][`NOC_VCN-1:0]  in_type;
   noc_flit_pkg::flit_data_t [4:0][`NOC_VCN-1:0]  in_data;
   noc_flit_pkg::coord_t [4:0][`NOC_VCN-1:0]      in_dst_x;
   noc_flit_pkg::coord_t [4:0][`NOC_VCN-1:0]      in_dst_y;
   logic [4:0]                                    out_valid;
   logic [4:0]                                    out_ready;
   noc_flit_pkg::flit_type_t [4:0]                out_type;
   noc_flit_pkg::flit_data_t [4:0]                out_data;
   noc_route_pkg::vc_t [4:0]                      out_vc;

   `include "tb_router_model.svh"

   logic [41:0]        send_q [NSRC][$];  // {dst_y, dst_x, type, data}
   logic [NSRC-1:0]    fired;
   int                 open_src [5];  // owner of each output, -1 when free
   int                 stall_cnt [5];
   logic [4:0]         held;  // stalled at the last edge
   logic [33:0]        held_flit [5];
   noc_route_pkg::vc_t held_vc [5];
   logic               stall_mode;
   int                 checks, errors, timeouts, queued, received;

   vc_router_sw i_vc_router_sw (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_flit(input int o);
      int          tag;
      int          src;
      logic        has_entry;
      logic [33:0] e;
      tag       = int'(out_data[o][31:28]);  // source port carried in the payload
      src       = tag * `NOC_VCN + int'(out_vc[o]);
      has_entry = 1'b0;
      received++;
      checks++;
      if (open_src[o] >= 0)
         assert (src == open_src[o]) else begin
            $display("[ERROR] t=%0t: packets interleaved on port %0d", $time, o);
            errors++;
         end
      if (tag < 5)
         has_entry = exp_q[queue_slot(o, tag, int'(out_vc[o]))].size() > 0;
      assert (has_entry) else begin
         $display("[ERROR] t=%0t: flit %h not expected on port %0d", $time, out_data[o], o);
         errors++;
      end
      if (has_entry) begin
         e = exp_q[queue_slot(o, tag, int'(out_vc[o]))].pop_front();
         assert (e[33:32] == out_type[o]) else begin
            $display("[ERROR] t=%0t: port %0d type %0d, expected %0d", $time, o,
                     out_type[o], e[33:32]);
            errors++;
         end
         assert (e[31:0] == out_data[o]) else begin
            $display("[ERROR] t=%0t: port %0d data %h, expected %h", $time, o,
                     out_data[o], e[31:0]);
            errors++;
         end
         if (e[33:32] == noc_flit_pkg::FLIT_HEAD)
            open_src[o] = src;
         else if (e[33:32] != noc_flit_pkg::FLIT_BODY)
            open_src[o] = -1;  // tail or single closes the packet
      end
   endtask

   task automatic sample_edge();
      for (int p = 0; p < 5; p++)
         for (int v = 0; v < `NOC_VCN; v++)
            fired[p*`NOC_VCN+v] = in_valid[p][v] & in_ready[p][v];
      for (int o = 0; o < 5; o++) begin
         if (held[o]) begin
            checks++;
            assert (out_valid[o] && ({out_type[o], out_data[o]} == held_flit[o]) &&
                    (out_vc[o] == held_vc[o])) else begin
               $display("[ERROR] t=%0t: port %0d changed while stalled", $time, o);
               errors++;
            end
         end
         held[o]      = out_valid[o] & ~out_ready[o];
         held_flit[o] = {out_type[o], out_data[o]};
         held_vc[o]   = out_vc[o];
         if (out_valid[o] && out_ready[o])
            check_flit(o);
      end
   endtask

   task automatic drive_inputs();
      logic [41:0] e;
      int          s;
      for (int p = 0; p < 5; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            s = p * `NOC_VCN + v;
            if (fired[s]) begin
               e        = send_q[s].pop_front();
               fired[s] = 1'b0;
            end
            in_valid[p][v] = send_q[s].size() > 0;
            if (send_q[s].size() > 0) begin
               e              = send_q[s][0];
               in_dst_y[p][v] = e[41:38];
               in_dst_x[p][v] = e[37:34];
               in_type[p][v]  = noc_flit_pkg::flit_type_t'(e[33:32]);
               in_data[p][v]  = e[31:0];
            end
         end
      end
      for (int o = 0; o < 5; o++) begin
         if (!stall_mode) begin
            out_ready[o] = 1'b1;
         end else if (stall_cnt[o] > 0) begin
            out_ready[o] = 1'b0;
            stall_cnt[o]--;
         end else begin
            out_ready[o] = 1'b1;
            if (take_bits(2) == 0)
               stall_cnt[o] = int'(take_bits(3)) + 1;  // stall of 1 to 8 cycles
         end
      end
   endtask

   // sample at the rising edge, drive at the falling edge
   initial begin
      forever begin
         @(posedge clk);
         if (rst_n)
            sample_edge();
         @(negedge clk);
         drive_inputs();
      end
   end

   task automatic queue_packet(input int p, input int v, input int o, input int len);
      logic [3:0]               dx;
      logic [3:0]               dy;
      logic [31:0]              r;
      logic [31:0]              data;
      noc_flit_pkg::flit_type_t ty;
      int                       port;
      dx = 4'(`NOC_ROUTER_X);
      dy = 4'(`NOC_ROUTER_Y);
      case (o)
         NORTH: begin
            dy = 4'(`NOC_ROUTER_Y + 1 + int'(take_bits(2)));
            dx = 4'(take_bits(4));
         end
         SOUTH: begin
            dy = 4'(int'(take_bits(3)) % `NOC_ROUTER_Y);
            dx = 4'(take_bits(4));
         end
         EAST:    dx = 4'(`NOC_ROUTER_X + 1 + int'(take_bits(2)));
         WEST:    dx = 4'(int'(take_bits(3)) % `NOC_ROUTER_X);
         default: dx = 4'(`NOC_ROUTER_X);
      endcase
      port = ref_route(int'(dx), int'(dy));
      for (int i = 0; i < len; i++) begin
         if (len == 1)
            ty = noc_flit_pkg::FLIT_SINGLE;
         else if (i == 0)
            ty = noc_flit_pkg::FLIT_HEAD;
         else if (i == len - 1)
            ty = noc_flit_pkg::FLIT_TAIL;
         else
            ty = noc_flit_pkg::FLIT_BODY;
         r    = take_bits(24);
         data = {4'(p), 4'(v), r[23:0]};  // source tag on top
         send_q[p*`NOC_VCN+v].push_back({dy, dx, ty, data});
         exp_q[queue_slot(port, p, v)].push_back({ty, data});
         queued++;
      end
   endtask

   task automatic random_packets(input int p, input int v, input int count);
      int o;
      for (int k = 0; k < count; k++) begin
         o = int'(take_bits(3)) % 5;
         while (!turn_allowed(p, o))
            o = (o + 1) % 5;
         queue_packet(p, v, o, 1 + int'(take_bits(2)));
      end
   endtask

   task automatic wait_drain(input int limit, input string what);
      int n;
      for (n = 0; n < limit; n++) begin
         @(negedge clk);
         if (scoreboard_empty() && (out_valid == '0))
            break;
      end
      if (n == limit) begin
         $display("timeout: %s did not drain within %0d cycles", what, limit);
         timeouts++;
      end
      @(posedge clk);
   endtask

   initial begin
      int target;
      rst_n      = 1'b0;
      in_valid   = '0;
      in_data    = '0;
      in_dst_x   = '0;
      in_dst_y   = '0;
      out_ready  = '1;
      stall_mode = 1'b0;
      held       = '0;
      fired      = '0;
      checks     = 0;
      errors     = 0;
      timeouts   = 0;
      queued     = 0;
      received   = 0;
      for (int p = 0; p < 5; p++) begin
         open_src[p]  = -1;
         stall_cnt[p] = 0;
         for (int v = 0; v < `NOC_VCN; v++)
            in_type[p][v] = noc_flit_pkg::FLIT_BODY;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // idle router stays quiet
      for (int c = 0; c < 20; c++) begin
         @(negedge clk);
         checks++;
         assert ((out_valid == '0) && (in_ready == '0)) else begin
            $display("[ERROR] t=%0t: activity on an idle router", $time);
            errors++;
         end
      end
      @(posedge clk);

      for (int p = 0; p < 5; p++)
         for (int v = 0; v < `NOC_VCN; v++)
            for (int o = 0; o < 5; o++)
               if (turn_allowed(p, o)) begin
                  queue_packet(p, v, o, 1);
                  wait_drain(50, "single flit");
               end

      // contention for one output
      for (int t = 0; t < 2; t++) begin
         target = (t == 0) ? LOCAL : WEST;
         for (int p = 0; p < 5; p++)
            for (int v = 0; v < `NOC_VCN; v++)
               if (turn_allowed(p, target)) begin
                  queue_packet(p, v, target, 2 + int'(take_bits(2)));
                  queue_packet(p, v, target, 2 + int'(take_bits(2)));
               end
         wait_drain(500, "packets to one output");
      end

      stall_mode = 1'b1;
      for (int v = 0; v < `NOC_VCN; v++) begin
         random_packets(SOUTH, v, 6);
         random_packets(LOCAL, v, 6);
      end
      wait_drain(2000, "traffic under back-pressure");

      for (int p = 0; p < 5; p++)
         for (int v = 0; v < `NOC_VCN; v++)
            random_packets(p, v, 8);
      wait_drain(5000, "random traffic on all ports");

      checks++;
      assert (scoreboard_empty() && (queued == received)) else begin
         $display("[ERROR] t=%0t: %0d flits queued, %0d received", $time, queued, received);
         errors++;
      end
      $display("checks %0d, errors %0d, timeouts %0d, flits %0d", checks, errors,
               timeouts, received);
      if ((errors == 0) && (timeouts == 0))
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- hdl/vc_router_sw.sv
`timescale 1ns/1ps
`include "noc_defines.svh"

module vc_router_sw (
   input  logic clk,
   input  logic rst_n,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_valid,
   output logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_ready,
   input  noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_type,
   input  noc_flit_pkg::flit_data_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_data,
   input  noc_flit_pkg::coord_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_dst_x,
   input  noc_flit_pkg::coord_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_dst_y,
   output logic [noc_route_pkg::NUM_PORTS-1:0] out_valid,
   input  logic [noc_route_pkg::NUM_PORTS-1:0] out_ready,
   output noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0] out_type,
   output noc_flit_pkg::flit_data_t [noc_route_pkg::NUM_PORTS-1:0] out_data,
   output noc_route_pkg::vc_t [noc_route_pkg::NUM_PORTS-1:0] out_vc
);

   localparam int NP = noc_route_pkg::NUM_PORTS;

   noc_route_pkg::guide4_t [`NOC_VCN-1:0] s_guide, n_guide, l_guide;
   noc_route_pkg::guide2_t [`NOC_VCN-1:0] w_guide, e_guide;
   logic [NP-1:0][`NOC_VCN-1:0]           in_fire;
   logic [NP-1:0][`NOC_VCN-1:0]           grant;
   logic [NP-1:0]                         out_free;
   logic [NP-1:0]                         xb_valid;
   noc_flit_pkg::flit_type_t [NP-1:0]     xb_type;
   noc_flit_pkg::flit_data_t [NP-1:0]     xb_data;
   noc_route_pkg::vc_t [NP-1:0]           xb_vc;

   assign in_fire  = in_valid & in_ready;
   assign out_free = ~out_valid | out_ready;  // empty or draining this cycle

   route_guide i_route_guide (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_type  (in_type),
      .in_dst_x (in_dst_x),
      .in_dst_y (in_dst_y),
      .in_fire  (in_fire),
      .s_guide  (s_guide),
      .n_guide  (n_guide),
      .l_guide  (l_guide),
      .w_guide  (w_guide),
      .e_guide  (e_guide)
   );

   sw_alloc i_sw_alloc (
      .clk      (clk),
      .rst_n    (rst_n),
      .s_guide  (s_guide),
      .n_guide  (n_guide),
      .l_guide  (l_guide),
      .w_guide  (w_guide),
      .e_guide  (e_guide),
      .in_valid (in_valid),
      .in_type  (in_type),
      .in_fire  (in_fire),
      .grant    (grant)
   );

   vc_data_crossbar i_vc_data_crossbar (
      .in_type  (in_type),
      .in_data  (in_data),
      .s_guide  (s_guide),
      .n_guide  (n_guide),
      .l_guide  (l_guide),
      .w_guide  (w_guide),
      .e_guide  (e_guide),
      .grant    (grant),
      .out_free (out_free),
      .in_ready (in_ready),
      .xb_valid (xb_valid),
      .xb_type  (xb_type),
      .xb_data  (xb_data),
      .xb_vc    (xb_vc)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= '0;
      end else begin
         for (int o = 0; o < NP; o++) begin
            if (out_free[o])
               out_valid[o] <= xb_valid[o];
         end
      end
   end

   // output payload, held while the downstream stalls
   always_ff @(posedge clk) begin
      for (int o = 0; o < NP; o++) begin
         if (out_free[o] && xb_valid[o]) begin
            out_type[o] <= xb_type[o];
            out_data[o] <= xb_data[o];
            out_vc[o]   <= xb_vc[o];
         end
      end
   end

endmodule

//--- hdl/vc_data_crossbar.sv
`timescale 1ns/1ps
`include "noc_defines.svh"

module vc_data_crossbar (
   input  noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_type,
   input  noc_flit_pkg::flit_data_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_data,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] s_guide,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] n_guide,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] l_guide,
   input  noc_route_pkg::guide2_t [`NOC_VCN-1:0] w_guide,
   input  noc_route_pkg::guide2_t [`NOC_VCN-1:0] e_guide,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] grant,
   input  logic [noc_route_pkg::NUM_PORTS-1:0] out_free,
   output logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_ready,
   output logic [noc_route_pkg::NUM_PORTS-1:0] xb_valid,
   output noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0] xb_type,
   output noc_flit_pkg::flit_data_t [noc_route_pkg::NUM_PORTS-1:0] xb_data,
   output noc_route_pkg::vc_t [noc_route_pkg::NUM_PORTS-1:0] xb_vc
);

   localparam int NP = noc_route_pkg::NUM_PORTS;
   localparam int TW = $bits(noc_flit_pkg::flit_type_t);

   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] omask;  // legal outputs per input vc
   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] steer;  // granted lane
   logic [NP-1:0][TW-1:0]               type_or;

   for (genvar v = 0; v < `NOC_VCN; v++) begin : g_dmx
      assign omask[noc_route_pkg::PORT_S][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_S, s_guide[v]);
      assign omask[noc_route_pkg::PORT_W][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_W, {2'b00, w_guide[v]});
      assign omask[noc_route_pkg::PORT_N][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_N, n_guide[v]);
      assign omask[noc_route_pkg::PORT_E][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_E, {2'b00, e_guide[v]});
      assign omask[noc_route_pkg::PORT_L][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_L, l_guide[v]);
   end

   // demux stage, only a granted vc puts its flit on a lane
   always_comb begin
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            steer[p][v] = omask[p][v] & {NP{grant[p][v]}};
            // ack comes from the output that the guide selects
            in_ready[p][v] = grant[p][v] & (|(omask[p][v] & out_free));
         end
      end
   end

   // merge stage
   // south gets n l, west s n e l, north s l, east s w n l, local s w n e
   always_comb begin
      xb_valid = '0;
      xb_data  = '0;
      xb_vc    = '0;
      type_or  = '0;
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            for (int o = 0; o < NP; o++) begin
               if (steer[p][v][o]) begin
                  xb_valid[o] = 1'b1;
                  type_or[o]  = type_or[o] | in_type[p][v];
                  xb_data[o]  = xb_data[o] | in_data[p][v];
                  xb_vc[o]    = xb_vc[o] | noc_route_pkg::vc_t'(v);
               end
            end
         end
      end
   end

   always_comb begin
      for (int o = 0; o < NP; o++)
         xb_type[o] = noc_flit_pkg::flit_type_t'(type_or[o]);
   end

endmodule

//--- hdl/sw_alloc.sv
`timescale 1ns/1ps
`include "noc_defines.svh"

module sw_alloc (
   input  logic clk,
   input  logic rst_n,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] s_guide,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] n_guide,
   input  noc_route_pkg::guide4_t [`NOC_VCN-1:0] l_guide,
   input  noc_route_pkg::guide2_t [`NOC_VCN-1:0] w_guide,
   input  noc_route_pkg::guide2_t [`NOC_VCN-1:0] e_guide,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_valid,
   input  noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_type,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_fire,
   output logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] grant
);

   localparam int NP = noc_route_pkg::NUM_PORTS;
   localparam int NR = NP * `NOC_VCN;  // requesters in port major order
   localparam int PW = $clog2(NR);

   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] omask;
   logic [NP-1:0][NR-1:0]               req;  // per output
   logic [NP-1:0][NR-1:0]               gnt;
   logic [NR-1:0]                       fire_f;
   logic [NR-1:0]                       tail_f;
   logic [NP-1:0]                       locked;
   logic [NP-1:0][PW-1:0]               owner;
   logic [NP-1:0][PW-1:0]               ptr;  // highest priority requester

   for (genvar v = 0; v < `NOC_VCN; v++) begin : g_mask
      assign omask[noc_route_pkg::PORT_S][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_S, s_guide[v]);
      assign omask[noc_route_pkg::PORT_W][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_W, {2'b00, w_guide[v]});
      assign omask[noc_route_pkg::PORT_N][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_N, n_guide[v]);
      assign omask[noc_route_pkg::PORT_E][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_E, {2'b00, e_guide[v]});
      assign omask[noc_route_pkg::PORT_L][v] =
         noc_route_pkg::guide_mask(noc_route_pkg::PORT_L, l_guide[v]);
   end

   // flatten requests per output
   always_comb begin
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            for (int o = 0; o < NP; o++)
               req[o][p*`NOC_VCN+v] = in_valid[p][v] & omask[p][v][o];
         end
      end
   end

   // accepted flits and their tail marks per requester
   always_comb begin
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            fire_f[p*`NOC_VCN+v] = in_fire[p][v];
            tail_f[p*`NOC_VCN+v] = noc_flit_pkg::is_tail(in_type[p][v]);
         end
      end
   end

   // a locked output serves its owner and a free one picks round robin from ptr
   always_comb begin
      int   idx;
      logic found;
      gnt = '0;
      idx = 0;
      for (int o = 0; o < NP; o++) begin
         found = 1'b0;
         if (locked[o]) begin
            gnt[o][owner[o]] = req[o][owner[o]];
         end else begin
            for (int k = 0; k < NR; k++) begin
               idx = (int'(ptr[o]) + k) % NR;
               if (!found && req[o][idx]) begin
                  gnt[o][idx] = 1'b1;
                  found       = 1'b1;
               end
            end
         end
      end
   end

   // each requester is guided to one output only
   always_comb begin
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            grant[p][v] = 1'b0;
            for (int o = 0; o < NP; o++)
               grant[p][v] = grant[p][v] | gnt[o][p*`NOC_VCN+v];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         locked <= '0;
         owner  <= '0;
         ptr    <= '0;
      end else begin
         for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NR; i++) begin
               if (gnt[o][i] && fire_f[i]) begin
                  if (tail_f[i]) begin
                     locked[o] <= 1'b0;  // packet done
                     ptr[o]    <= (i == NR - 1) ? '0 : PW'(i + 1);
                  end else begin
                     locked[o] <= 1'b1;
                     owner[o]  <= PW'(i);
                  end
               end
            end
         end
      end
   end

endmodule

//--- hdl/route_guide.sv
`timescale 1ns/1ps
`include "noc_defines.svh"

module route_guide (
   input  logic clk,
   input  logic rst_n,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_valid,
   input  noc_flit_pkg::flit_type_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_type,
   input  noc_flit_pkg::coord_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_dst_x,
   input  noc_flit_pkg::coord_t [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_dst_y,
   input  logic [noc_route_pkg::NUM_PORTS-1:0][`NOC_VCN-1:0] in_fire,
   output noc_route_pkg::guide4_t [`NOC_VCN-1:0] s_guide,
   output noc_route_pkg::guide4_t [`NOC_VCN-1:0] n_guide,
   output noc_route_pkg::guide4_t [`NOC_VCN-1:0] l_guide,
   output noc_route_pkg::guide2_t [`NOC_VCN-1:0] w_guide,
   output noc_route_pkg::guide2_t [`NOC_VCN-1:0] e_guide
);

   localparam int NP = noc_route_pkg::NUM_PORTS;
   localparam noc_flit_pkg::coord_t ROUTER_X = `NOC_ROUTER_X;
   localparam noc_flit_pkg::coord_t ROUTER_Y = `NOC_ROUTER_Y;

   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] head_mask;  // decoded from dst
   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] held_mask;  // guide of the open packet
   logic [NP-1:0][`NOC_VCN-1:0][NP-1:0] cur_mask;
   logic [NP-1:0][`NOC_VCN-1:0]         head_in;

   // y first, then x
   always_comb begin
      noc_route_pkg::port_t dir;
      for (int p = 0; p < NP; p++) begin
         for (int v = 0; v < `NOC_VCN; v++) begin
            if (in_dst_y[p][v] > ROUTER_Y)
               dir = noc_route_pkg::PORT_N;
            else if (in_dst_y[p][v] < ROUTER_Y)
               dir = noc_route_pkg::PORT_S;
            else if (in_dst_x[p][v] > ROUTER_X)
               dir = noc_route_pkg::PORT_E;
            else if (in_dst_x[p][v] < ROUTER_X)
               dir = noc_route_pkg::PORT_W;
            else
               dir = noc_route_pkg::PORT_L;
            head_mask[p][v]      = '0;
            head_mask[p][v][dir] = 1'b1;
            head_in[p][v]   = in_valid[p][v] && noc_flit_pkg::is_head(in_type[p][v]);
            cur_mask[p][v]  = head_in[p][v] ? head_mask[p][v] : held_mask[p][v];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         held_mask <= '0;
      end else begin
         for (int p = 0; p < NP; p++) begin
            for (int v = 0; v < `NOC_VCN; v++) begin
               if (in_fire[p][v] && head_in[p][v])
                  held_mask[p][v] <= head_mask[p][v];  // body and tail follow
            end
         end
      end
   end

   // fold the full masks into each input's own guide, illegal turns drop out
   for (genvar v = 0; v < `NOC_VCN; v++) begin : g_enc
      logic [NP-1:0] sm, wm, nm, em, lm;
      assign sm = cur_mask[noc_route_pkg::PORT_S][v];
      assign wm = cur_mask[noc_route_pkg::PORT_W][v];
      assign nm = cur_mask[noc_route_pkg::PORT_N][v];
      assign em = cur_mask[noc_route_pkg::PORT_E][v];
      assign lm = cur_mask[noc_route_pkg::PORT_L][v];

      assign s_guide[v] = {sm[4], sm[3], sm[2], sm[1]};  // l e n w
      assign n_guide[v] = {nm[4], nm[3], nm[1], nm[0]};  // l e w s
      assign l_guide[v] = {lm[3], lm[2], lm[1], lm[0]};  // e n w s
      assign w_guide[v] = {wm[4], wm[3]};                // l e
      assign e_guide[v] = {em[4], em[1]};                // l w
   end

endmodule

//--- hdl/noc_route_pkg.sv
`include "noc_defines.svh"

package noc_route_pkg;

   localparam int NUM_PORTS = 5;

   typedef logic [2:0] port_t;

   localparam port_t PORT_S = 3'd0;
   localparam port_t PORT_W = 3'd1;
   localparam port_t PORT_N = 3'd2;
   localparam port_t PORT_E = 3'd3;
   localparam port_t PORT_L = 3'd4;

   typedef logic [3:0] guide4_t;  // south, north and local inputs
   typedef logic [1:0] guide2_t;  // west and east inputs

   typedef logic [$clog2(`NOC_VCN)-1:0] vc_t;

   // expands an input's restricted guide into a mask over all five outputs,
   // turns that are not in the turn set stay zero
   function automatic logic [NUM_PORTS-1:0] guide_mask(port_t src, guide4_t g);
      logic [NUM_PORTS-1:0] m;
      case (src)
         PORT_S:  m = {g[3], g[2], g[1], g[0], 1'b0};  // w n e l
         PORT_W:  m = {g[1], g[0], 3'b000};            // e l
         PORT_N:  m = {g[3], g[2], 1'b0, g[1], g[0]};  // s w e l
         PORT_E:  m = {g[1], 2'b00, g[0], 1'b0};       // w l
         default: m = {1'b0, g[3], g[2], g[1], g[0]};  // local: s w n e
      endcase
      return m;
   endfunction

endpackage

//--- hdl/noc_flit_pkg.sv
`include "noc_defines.svh"

package noc_flit_pkg;

   // bit 0 marks a head, bit 1 marks a tail
   typedef enum logic [1:0] {
      FLIT_BODY   = 2'b00,
      FLIT_HEAD   = 2'b01,
      FLIT_TAIL   = 2'b10,
      FLIT_SINGLE = 2'b11  // head and tail at once
   } flit_type_t;

   typedef logic [`NOC_DW-1:0] flit_data_t;

   typedef logic [`NOC_CW-1:0] coord_t;

   // opens a packet
   function automatic logic is_head(flit_type_t t);
      return (t == FLIT_HEAD) || (t == FLIT_SINGLE);
   endfunction

   // closes a packet
   function automatic logic is_tail(flit_type_t t);
      return (t == FLIT_TAIL) || (t == FLIT_SINGLE);
   endfunction

endpackage

//--- hdl/noc_defines.svh
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// payload word of one flit
`define NOC_DW 32

// virtual channels on every input port
`define NOC_VCN 2

// bits in one mesh coordinate
`define NOC_CW 4

// position of this router in the mesh
`define NOC_ROUTER_X 5
`define NOC_ROUTER_Y 5

`endif
